/* Bender.yml */
package:
  name: x86_pipeline

sources:
  - rtl/x86_pipe_pkg.sv
  - rtl/decode_stage.sv
  - rtl/register_file.sv
  - rtl/operand_stage.sv
  - rtl/execute.sv
  - rtl/x86_pipeline.sv
  - target: test
    files:
      - verification/x86_pipeline_properties.sv
      - verification/x86_pipeline_tb.sv

/* all.f */
rtl/x86_pipe_pkg.sv
rtl/decode_stage.sv
rtl/register_file.sv
rtl/operand_stage.sv
rtl/execute.sv
rtl/x86_pipeline.sv
verification/x86_pipeline_properties.sv
verification/x86_pipeline_tb.sv

/* rtl/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
   input  logic                              CLK,
   input  logic                              rst,
   input  logic                              ir_valid,
   input  logic [x86_pipe_pkg::IR_W-1:0]     ir,
   output logic                              de_valid,
   output logic [x86_pipe_pkg::ALUK_W-1:0]   de_aluk,
   output logic [x86_pipe_pkg::GPR_ID_W-1:0] de_dr,
   output logic [x86_pipe_pkg::GPR_ID_W-1:0] de_sr,
   output logic                              de_use_imm,
   output logic [x86_pipe_pkg::GPR_W-1:0]    de_imm,
   output logic                              de_opsize16
);

   // Fetched window and its strobe
   logic                          ir_v_q;
   logic [x86_pipe_pkg::IR_W-1:0] ir_q;

   logic                          has_pfx;
   logic [x86_pipe_pkg::IR_W-1:0] body;
   logic [7:0]                    opc;
   logic [7:0]                    modrm;
   logic [x86_pipe_pkg::GPR_W-1:0] imm;
   logic                          dec_ok;
   logic                          dec_use_imm;
   logic [x86_pipe_pkg::ALUK_W-1:0] dec_aluk;

   function automatic logic [7:0] byte_at(input logic [x86_pipe_pkg::IR_W-1:0] win,
                                          input int n);
      return win[x86_pipe_pkg::IR_W-1-8*n -: 8];
   endfunction

   always_ff @(posedge CLK) begin
      if (rst) begin
         ir_v_q <= 1'b0;
      end else begin
         ir_v_q <= ir_valid;
      end
   end

   always_ff @(posedge CLK) begin
      ir_q <= ir;
   end

   // Drop the 66h byte so the opcode always sits in byte 0
   assign has_pfx = byte_at(ir_q, 0) == x86_pipe_pkg::PFX_OPSIZE;
   assign body    = has_pfx ? {ir_q[x86_pipe_pkg::IR_W-9:0], 8'h00} : ir_q;
   assign opc     = byte_at(body, 0);
   assign modrm   = byte_at(body, 1);

   // imm32 is little endian right after ModRM
   assign imm = {byte_at(body, 5), byte_at(body, 4), byte_at(body, 3), byte_at(body, 2)};

   always_comb begin
      dec_ok      = 1'b0;
      dec_use_imm = 1'b0;
      // Register forms carry the operation in opcode bits 5:3
      dec_aluk    = opc[5:3];
      case (opc)
         x86_pipe_pkg::OPC_ADD_RR,
         x86_pipe_pkg::OPC_OR_RR,
         x86_pipe_pkg::OPC_AND_RR,
         x86_pipe_pkg::OPC_SUB_RR,
         x86_pipe_pkg::OPC_XOR_RR: begin
            dec_ok = 1'b1;
         end
         x86_pipe_pkg::OPC_GRP1_IMM: begin
            dec_use_imm = 1'b1;
            dec_aluk    = modrm[5:3];
            case (modrm[5:3])
               x86_pipe_pkg::ALUK_ADD,
               x86_pipe_pkg::ALUK_OR,
               x86_pipe_pkg::ALUK_AND,
               x86_pipe_pkg::ALUK_SUB,
               x86_pipe_pkg::ALUK_XOR: dec_ok = 1'b1;
               // ADC, SBB and CMP not supported
               default: dec_ok = 1'b0;
            endcase
         end
         default: dec_ok = 1'b0;
      endcase
      // Memory operands are outside this slice
      if (modrm[7:6] != x86_pipe_pkg::MOD_REG) begin
         dec_ok = 1'b0;
      end
   end

   always_ff @(posedge CLK) begin
      if (rst) begin
         de_valid <= 1'b0;
      end else begin
         de_valid <= ir_v_q & dec_ok;
      end
   end

   always_ff @(posedge CLK) begin
      de_aluk     <= dec_aluk;
      de_dr       <= modrm[2:0];
      de_sr       <= modrm[5:3];
      de_use_imm  <= dec_use_imm;
      de_imm      <= imm;
      de_opsize16 <= has_pfx;
   end

endmodule

/* rtl/execute.sv */
`timescale 1ns/10ps

module execute (
   input  logic                              CLK,
   input  logic                              rst,
   input  logic                              op_valid,
   input  logic [x86_pipe_pkg::ALUK_W-1:0]   op_aluk,
   input  logic [x86_pipe_pkg::GPR_ID_W-1:0] op_dr,
   input  logic [x86_pipe_pkg::GPR_W-1:0]    op_a,
   input  logic [x86_pipe_pkg::GPR_W-1:0]    op_b,
   input  logic                              op_opsize16,
   output logic                              ex_valid,
   output logic [x86_pipe_pkg::GPR_ID_W-1:0] ex_dr,
   output logic [x86_pipe_pkg::GPR_W-1:0]    ex_data,
   output logic                              wb_valid,
   output logic [x86_pipe_pkg::GPR_ID_W-1:0] wb_dr,
   output logic [x86_pipe_pkg::GPR_W-1:0]    wb_data,
   output logic [x86_pipe_pkg::FLAGS_W-1:0]  wb_flags
);

   localparam int W = x86_pipe_pkg::GPR_W;
   localparam int H = x86_pipe_pkg::HALF_W;

   // Extra top bit holds carry or borrow
   logic [W:0]   add_w;
   logic [W:0]   sub_w;
   logic [H:0]   add_h;
   logic [H:0]   sub_h;
   logic [W-1:0] res;
   logic         a_s;
   logic         b_s;
   logic         r_s;
   logic         carry;
   logic         ovf;
   logic [x86_pipe_pkg::FLAGS_W-1:0] flags;

   assign add_w = {1'b0, op_a} + {1'b0, op_b};
   assign sub_w = {1'b0, op_a} - {1'b0, op_b};
   assign add_h = {1'b0, op_a[H-1:0]} + {1'b0, op_b[H-1:0]};
   assign sub_h = {1'b0, op_a[H-1:0]} - {1'b0, op_b[H-1:0]};

   always_comb begin
      case (op_aluk)
         x86_pipe_pkg::ALUK_ADD: res = add_w[W-1:0];
         x86_pipe_pkg::ALUK_SUB: res = sub_w[W-1:0];
         x86_pipe_pkg::ALUK_OR:  res = op_a | op_b;
         x86_pipe_pkg::ALUK_AND: res = op_a & op_b;
         x86_pipe_pkg::ALUK_XOR: res = op_a ^ op_b;
         default:                res = '0;
      endcase
   end

   // Sign bits at the operating width
   assign a_s = op_opsize16 ? op_a[H-1] : op_a[W-1];
   assign b_s = op_opsize16 ? op_b[H-1] : op_b[W-1];
   assign r_s = op_opsize16 ? res[H-1] : res[W-1];

   always_comb begin
      carry = 1'b0;
      ovf   = 1'b0;
      if (op_aluk == x86_pipe_pkg::ALUK_ADD) begin
         carry = op_opsize16 ? add_h[H] : add_w[W];
         ovf   = (a_s == b_s) && (r_s != a_s);
      end else if (op_aluk == x86_pipe_pkg::ALUK_SUB) begin
         carry = op_opsize16 ? sub_h[H] : sub_w[W];
         ovf   = (a_s != b_s) && (r_s != a_s);
      end
      flags = '0;
      flags[x86_pipe_pkg::FLAG_CF] = carry;
      flags[x86_pipe_pkg::FLAG_ZF] = op_opsize16 ? (res[H-1:0] == '0) : (res == '0);
      flags[x86_pipe_pkg::FLAG_SF] = r_s;
      flags[x86_pipe_pkg::FLAG_OF] = ovf;
   end

   // 16-bit ops leave the upper half of the destination alone
   assign ex_data  = op_opsize16 ? {op_a[W-1:H], res[H-1:0]} : res;
   assign ex_valid = op_valid;
   assign ex_dr    = op_dr;

   always_ff @(posedge CLK) begin
      if (rst) begin
         wb_valid <= 1'b0;
      end else begin
         wb_valid <= op_valid;
      end
   end

   always_ff @(posedge CLK) begin
      wb_dr    <= op_dr;
      wb_data  <= ex_data;
      wb_flags <= flags;
   end

endmodule

/* rtl/operand_stage.sv */
`timescale 1ns/10ps

module operand_stage (
   input  logic                              CLK,
   input  logic                              rst,
   input  logic                              de_valid,
   input  logic [x86_pipe_pkg::ALUK_W-1:0]   de_aluk,
   input  logic [x86_pipe_pkg::GPR_ID_W-1:0] de_dr,
   input  logic [x86_pipe_pkg::GPR_ID_W-1:0] de_sr,
   input  logic                              de_use_imm,
   input  logic [x86_pipe_pkg::GPR_W-1:0]    de_imm,
   input  logic                              de_opsize16,
   input  logic [x86_pipe_pkg::GPR_W-1:0]    rd_data_a,
   input  logic [x86_pipe_pkg::GPR_W-1:0]    rd_data_b,
   input  logic                              ex_valid,
   input  logic [x86_pipe_pkg::GPR_ID_W-1:0] ex_dr,
   input  logic [x86_pipe_pkg::GPR_W-1:0]    ex_data,
   input  logic                              wb_valid,
   input  logic [x86_pipe_pkg::GPR_ID_W-1:0] wb_dr,
   input  logic [x86_pipe_pkg::GPR_W-1:0]    wb_data,
   output logic [x86_pipe_pkg::GPR_ID_W-1:0] rd_id_a,
   output logic [x86_pipe_pkg::GPR_ID_W-1:0] rd_id_b,
   output logic                              op_valid,
   output logic [x86_pipe_pkg::ALUK_W-1:0]   op_aluk,
   output logic [x86_pipe_pkg::GPR_ID_W-1:0] op_dr,
   output logic [x86_pipe_pkg::GPR_W-1:0]    op_a,
   output logic [x86_pipe_pkg::GPR_W-1:0]    op_b,
   output logic                              op_opsize16
);

   logic [x86_pipe_pkg::GPR_W-1:0] fwd_a;
   logic [x86_pipe_pkg::GPR_W-1:0] fwd_b;
   logic [x86_pipe_pkg::GPR_W-1:0] opnd_b;

   // Youngest producer wins, EX before WB before the file
   function automatic logic [x86_pipe_pkg::GPR_W-1:0] forward(
      input logic [x86_pipe_pkg::GPR_ID_W-1:0] id,
      input logic [x86_pipe_pkg::GPR_W-1:0]    rf_data
   );
      logic [x86_pipe_pkg::GPR_W-1:0] sel;
      sel = rf_data;
      if (ex_valid && ex_dr == id) begin
         sel = ex_data;
      end else if (wb_valid && wb_dr == id) begin
         sel = wb_data;
      end
      return sel;
   endfunction

   // Destination doubles as the first operand
   assign rd_id_a = de_dr;
   assign rd_id_b = de_sr;

   always_comb begin
      fwd_a = forward(de_dr, rd_data_a);
      fwd_b = forward(de_sr, rd_data_b);
   end

   assign opnd_b = de_use_imm ? de_imm : fwd_b;

   always_ff @(posedge CLK) begin
      if (rst) begin
         op_valid <= 1'b0;
      end else begin
         op_valid <= de_valid;
      end
   end

   always_ff @(posedge CLK) begin
      op_aluk     <= de_aluk;
      op_dr       <= de_dr;
      op_a        <= fwd_a;
      op_b        <= opnd_b;
      op_opsize16 <= de_opsize16;
   end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/10ps

module register_file (
   input  logic                              CLK,
   input  logic                              rst,
   input  logic [x86_pipe_pkg::GPR_ID_W-1:0] rd_id_a,
   input  logic [x86_pipe_pkg::GPR_ID_W-1:0] rd_id_b,
   input  logic                              wr_en,
   input  logic [x86_pipe_pkg::GPR_ID_W-1:0] wr_id,
   input  logic [x86_pipe_pkg::GPR_W-1:0]    wr_data,
   output logic [x86_pipe_pkg::GPR_W-1:0]    rd_data_a,
   output logic [x86_pipe_pkg::GPR_W-1:0]    rd_data_b
);

   // EAX..EDI in encoding order
   logic [x86_pipe_pkg::GPR_W-1:0] gpr [x86_pipe_pkg::NUM_GPR];

   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int i = 0; i < x86_pipe_pkg::NUM_GPR; i++) begin
            gpr[i] <= '0;
         end
      end else if (wr_en) begin
         gpr[wr_id] <= wr_data;
      end
   end

   // Reads see the old value during a write
   assign rd_data_a = gpr[rd_id_a];
   assign rd_data_b = gpr[rd_id_b];

endmodule

/* rtl/x86_pipe_pkg.sv */
package x86_pipe_pkg;

   // Datapath widths
   localparam int GPR_W    = 32;
   localparam int HALF_W   = 16;
   localparam int GPR_ID_W = 3;
   localparam int NUM_GPR  = 8;

   // Instruction window, byte 0 in the top byte
   localparam int IR_W = 64;

   // ALU operation codes, same values as the x86 group-1 /reg field
   localparam int ALUK_W = 3;
   localparam logic [ALUK_W-1:0] ALUK_ADD = 3'd0;
   localparam logic [ALUK_W-1:0] ALUK_OR  = 3'd1;
   localparam logic [ALUK_W-1:0] ALUK_AND = 3'd4;
   localparam logic [ALUK_W-1:0] ALUK_SUB = 3'd5;
   localparam logic [ALUK_W-1:0] ALUK_XOR = 3'd6;

   // Register-form opcodes, r/m32 op r32
   localparam logic [7:0] OPC_ADD_RR = 8'h01;
   localparam logic [7:0] OPC_OR_RR  = 8'h09;
   localparam logic [7:0] OPC_AND_RR = 8'h21;
   localparam logic [7:0] OPC_SUB_RR = 8'h29;
   localparam logic [7:0] OPC_XOR_RR = 8'h31;

   // Group 1 with imm32
   localparam logic [7:0] OPC_GRP1_IMM = 8'h81;

   // Operand-size override
   localparam logic [7:0] PFX_OPSIZE = 8'h66;

   // ModRM register form
   localparam logic [1:0] MOD_REG = 2'b11;

   // Flag vector layout
   localparam int FLAGS_W = 4;
   localparam int FLAG_CF = 0;
   localparam int FLAG_ZF = 1;
   localparam int FLAG_SF = 2;
   localparam int FLAG_OF = 3;

endpackage

/* rtl/x86_pipeline.sv */
`timescale 1ns/10ps

module x86_pipeline (
   input  logic                              CLK,
   input  logic                              rst,
   input  logic                              ir_valid,
   input  logic [x86_pipe_pkg::IR_W-1:0]     ir,
   output logic                              retire_valid,
   output logic [x86_pipe_pkg::GPR_ID_W-1:0] retire_dr,
   output logic [x86_pipe_pkg::GPR_W-1:0]    retire_data,
   output logic [x86_pipe_pkg::FLAGS_W-1:0]  retire_flags
);

   // Decode to operand fetch
   logic                              de_valid;
   logic [x86_pipe_pkg::ALUK_W-1:0]   de_aluk;
   logic [x86_pipe_pkg::GPR_ID_W-1:0] de_dr;
   logic [x86_pipe_pkg::GPR_ID_W-1:0] de_sr;
   logic                              de_use_imm;
   logic [x86_pipe_pkg::GPR_W-1:0]    de_imm;
   logic                              de_opsize16;

   // Register file read ports
   logic [x86_pipe_pkg::GPR_ID_W-1:0] rd_id_a;
   logic [x86_pipe_pkg::GPR_ID_W-1:0] rd_id_b;
   logic [x86_pipe_pkg::GPR_W-1:0]    rd_data_a;
   logic [x86_pipe_pkg::GPR_W-1:0]    rd_data_b;

   // Operand fetch to execute
   logic                              op_valid;
   logic [x86_pipe_pkg::ALUK_W-1:0]   op_aluk;
   logic [x86_pipe_pkg::GPR_ID_W-1:0] op_dr;
   logic [x86_pipe_pkg::GPR_W-1:0]    op_a;
   logic [x86_pipe_pkg::GPR_W-1:0]    op_b;
   logic                              op_opsize16;

   // Forwarding sources and writeback
   logic                              ex_valid;
   logic [x86_pipe_pkg::GPR_ID_W-1:0] ex_dr;
   logic [x86_pipe_pkg::GPR_W-1:0]    ex_data;
   logic                              wb_valid;
   logic [x86_pipe_pkg::GPR_ID_W-1:0] wb_dr;
   logic [x86_pipe_pkg::GPR_W-1:0]    wb_data;
   logic [x86_pipe_pkg::FLAGS_W-1:0]  wb_flags;

   decode_stage decode_stage_inst (
      .CLK, .rst, .ir_valid, .ir,
      .de_valid, .de_aluk, .de_dr, .de_sr, .de_use_imm, .de_imm, .de_opsize16
   );

   register_file register_file_inst (
      .CLK, .rst, .rd_id_a, .rd_id_b,
      .wr_en(wb_valid), .wr_id(wb_dr), .wr_data(wb_data),
      .rd_data_a, .rd_data_b
   );

   operand_stage operand_stage_inst (
      .CLK, .rst,
      .de_valid, .de_aluk, .de_dr, .de_sr, .de_use_imm, .de_imm, .de_opsize16,
      .rd_data_a, .rd_data_b,
      .ex_valid, .ex_dr, .ex_data, .wb_valid, .wb_dr, .wb_data,
      .rd_id_a, .rd_id_b,
      .op_valid, .op_aluk, .op_dr, .op_a, .op_b, .op_opsize16
   );

   execute execute_inst (
      .CLK, .rst,
      .op_valid, .op_aluk, .op_dr, .op_a, .op_b, .op_opsize16,
      .ex_valid, .ex_dr, .ex_data,
      .wb_valid, .wb_dr, .wb_data, .wb_flags
   );

   // Retire is the register file write
   assign retire_valid = wb_valid;
   assign retire_dr    = wb_dr;
   assign retire_data  = wb_data;
   assign retire_flags = wb_flags;

endmodule

/* verification/x86_pipeline_properties.sv */
`timescale 1ns/10ps

module x86_pipeline_properties (
   input logic                              CLK,
   input logic                              rst,
   input logic                              ir_valid,
   input logic                              retire_valid,
   input logic [x86_pipe_pkg::GPR_ID_W-1:0] retire_dr,
   input logic [x86_pipe_pkg::GPR_W-1:0]    retire_data
);

   // Assertion failures so far
   int fail_count = 0;

   // Quiet during reset and in the first cycle after it
   property quiet_after_reset;
      @(posedge CLK) rst |=> !retire_valid ##1 !retire_valid;
   endproperty

   // Issue edge is four sampling points back, i.e. three cycles of latency
   property retire_has_issue;
      @(posedge CLK) disable iff (rst) retire_valid |-> $past(ir_valid, 4);
   endproperty

   property retire_known;
      @(posedge CLK) disable iff (rst) retire_valid |-> !$isunknown({retire_dr, retire_data});
   endproperty

   assert property (quiet_after_reset)
      else begin
         fail_count++;
         $error("retire_valid high during or right after reset");
      end
   assert property (retire_has_issue)
      else begin
         fail_count++;
         $error("retire without an issue strobe three cycles earlier");
      end
   assert property (retire_known)
      else begin
         fail_count++;
         $error("retire_dr or retire_data unknown while retire_valid is high");
      end

endmodule

bind x86_pipeline x86_pipeline_properties x86_pipeline_properties_inst (
   .CLK, .rst, .ir_valid, .retire_valid, .retire_dr, .retire_data
);

/* verification/x86_pipeline_tb.sv */
`timescale 1ns/10ps

module x86_pipeline_tb;

   localparam int CLK_PERIOD = 8;
   localparam int MAX_TESTS  = 64;
   localparam int N_RAND     = 8;
   localparam int LATENCY    = 3;
   localparam int IW         = x86_pipe_pkg::IR_W;
   localparam int DW         = x86_pipe_pkg::GPR_W;
   localparam int RW         = x86_pipe_pkg::GPR_ID_W;
   localparam int FW         = x86_pipe_pkg::FLAGS_W;

   // Register numbers in ModRM order
   localparam logic [RW-1:0] EAX = 3'd0;
   localparam logic [RW-1:0] ECX = 3'd1;
   localparam logic [RW-1:0] EDX = 3'd2;
   localparam logic [RW-1:0] EBX = 3'd3;
   localparam logic [RW-1:0] ESI = 3'd6;
   localparam logic [RW-1:0] EDI = 3'd7;

   localparam logic [7:0] OP_ADD = x86_pipe_pkg::OPC_ADD_RR;
   localparam logic [7:0] OP_OR  = x86_pipe_pkg::OPC_OR_RR;
   localparam logic [7:0] OP_AND = x86_pipe_pkg::OPC_AND_RR;
   localparam logic [7:0] OP_SUB = x86_pipe_pkg::OPC_SUB_RR;
   localparam logic [7:0] OP_XOR = x86_pipe_pkg::OPC_XOR_RR;
   localparam logic [2:0] AK_ADD = x86_pipe_pkg::ALUK_ADD;
   localparam logic [2:0] AK_OR  = x86_pipe_pkg::ALUK_OR;
   localparam logic [2:0] AK_AND = x86_pipe_pkg::ALUK_AND;
   localparam logic [2:0] AK_SUB = x86_pipe_pkg::ALUK_SUB;
   localparam logic [2:0] AK_XOR = x86_pipe_pkg::ALUK_XOR;

   logic          CLK;
   logic          rst;
   logic          ir_valid;
   logic [IW-1:0] ir;
   logic          retire_valid;
   logic [RW-1:0] retire_dr;
   logic [DW-1:0] retire_data;
   logic [FW-1:0] retire_flags;

   // Stimulus and expected values, one row per instruction
   string         name_t  [MAX_TESTS];
   logic [IW-1:0] win_t   [MAX_TESTS];
   bit            exp_t   [MAX_TESTS];
   logic [RW-1:0] dr_t    [MAX_TESTS];
   logic [DW-1:0] data_t  [MAX_TESTS];
   logic [FW-1:0] flags_t [MAX_TESTS];
   logic [DW-1:0] model_gpr [x86_pipe_pkg::NUM_GPR];

   int n_tests = 0;
   int n_run   = 0;
   int n_pass  = 0;
   int n_fail  = 0;
   int n_other = 0;
   int test_err;
   int cycle   = 0;
   int seed;
   bit table_ready = 0;
   int pend_idx [$];
   int pend_edge [$];

   x86_pipeline x86_pipeline_inst (
      .CLK, .rst, .ir_valid, .ir,
      .retire_valid, .retire_dr, .retire_data, .retire_flags
   );

   always #(CLK_PERIOD / 2) CLK = ~CLK;

   always @(posedge CLK) begin
      cycle <= cycle + 1;
   end

   function automatic logic [IW-1:0] rr(input bit pfx, input logic [7:0] opc,
                                        input logic [RW-1:0] dst, input logic [RW-1:0] src);
      logic [7:0] modrm;
      modrm = {x86_pipe_pkg::MOD_REG, src, dst};
      if (pfx) begin
         return {x86_pipe_pkg::PFX_OPSIZE, opc, modrm, 40'h0};
      end
      return {opc, modrm, 48'h0};
   endfunction

   // 81h /ext with the immediate in little-endian byte order
   function automatic logic [IW-1:0] ri(input bit pfx, input logic [2:0] ext,
                                        input logic [RW-1:0] dst, input logic [DW-1:0] imm);
      logic [7:0]  modrm;
      logic [31:0] le;
      modrm = {x86_pipe_pkg::MOD_REG, ext, dst};
      le    = {imm[7:0], imm[15:8], imm[23:16], imm[31:24]};
      if (pfx) begin
         return {x86_pipe_pkg::PFX_OPSIZE, x86_pipe_pkg::OPC_GRP1_IMM, modrm, le, 8'h0};
      end
      return {x86_pipe_pkg::OPC_GRP1_IMM, modrm, le, 16'h0};
   endfunction

   function automatic logic [FW-1:0] flg(input bit cf, input bit zf, input bit sf, input bit of);
      logic [FW-1:0] f;
      f = '0;
      f[x86_pipe_pkg::FLAG_CF] = cf;
      f[x86_pipe_pkg::FLAG_ZF] = zf;
      f[x86_pipe_pkg::FLAG_SF] = sf;
      f[x86_pipe_pkg::FLAG_OF] = of;
      return f;
   endfunction

   task automatic add_entry(input string name, input logic [IW-1:0] win, input logic [RW-1:0] dr,
                            input logic [DW-1:0] data, input logic [FW-1:0] flags);
      name_t[n_tests]  = name;
      win_t[n_tests]   = win;
      exp_t[n_tests]   = 1'b1;
      dr_t[n_tests]    = dr;
      data_t[n_tests]  = data;
      flags_t[n_tests] = flags;
      model_gpr[dr]    = data;
      n_tests++;
   endtask

   task automatic add_invalid(input string name, input logic [IW-1:0] win);
      name_t[n_tests] = name;
      win_t[n_tests]  = win;
      exp_t[n_tests]  = 1'b0;
      n_tests++;
   endtask

   task automatic build_table();
      logic [DW-1:0] imm;
      logic [DW-1:0] res;
      logic [RW-1:0] dr;
      for (int i = 0; i < x86_pipe_pkg::NUM_GPR; i++) begin
         model_gpr[i] = '0;
      end
      add_entry("add_eax_ebx_zero", rr(0, OP_ADD, EAX, EBX), EAX, 32'h0, flg(0, 1, 0, 0));
      // Immediate forms
      add_entry("add_imm_ecx", ri(0, AK_ADD, ECX, 32'h7FFF_FFFF), ECX, 32'h7FFF_FFFF,
                flg(0, 0, 0, 0));
      add_entry("add_imm_ecx_ovf", ri(0, AK_ADD, ECX, 32'h1), ECX, 32'h8000_0000, flg(0, 0, 1, 1));
      add_entry("or_imm_edx", ri(0, AK_OR, EDX, 32'hF0F0), EDX, 32'hF0F0, flg(0, 0, 0, 0));
      add_entry("and_imm_edx", ri(0, AK_AND, EDX, 32'hF_F000), EDX, 32'hF000, flg(0, 0, 0, 0));
      add_entry("sub_imm_ebx_cf", ri(0, AK_SUB, EBX, 32'h1), EBX, 32'hFFFF_FFFF, flg(1, 0, 1, 0));
      add_entry("xor_imm_ebx", ri(0, AK_XOR, EBX, 32'hFFFF_FFFF), EBX, 32'h0, flg(0, 1, 0, 0));
      add_entry("sub_imm_ecx_ovf", ri(0, AK_SUB, ECX, 32'h1), ECX, 32'h7FFF_FFFF, flg(0, 0, 0, 1));
      // Dependent chain, distances 1 to 3
      add_entry("add_imm_esi", ri(0, AK_ADD, ESI, 32'h10), ESI, 32'h10, flg(0, 0, 0, 0));
      add_entry("add_edi_esi_ex", rr(0, OP_ADD, EDI, ESI), EDI, 32'h10, flg(0, 0, 0, 0));
      add_entry("add_edi_esi_wb", rr(0, OP_ADD, EDI, ESI), EDI, 32'h20, flg(0, 0, 0, 0));
      add_entry("sub_esi_edi", rr(0, OP_SUB, ESI, EDI), ESI, 32'hFFFF_FFF0, flg(1, 0, 1, 0));
      add_entry("or_eax_edi", rr(0, OP_OR, EAX, EDI), EAX, 32'h20, flg(0, 0, 0, 0));
      add_entry("and_edi_esi", rr(0, OP_AND, EDI, ESI), EDI, 32'h20, flg(0, 0, 0, 0));
      add_entry("xor_eax_eax", rr(0, OP_XOR, EAX, EAX), EAX, 32'h0, flg(0, 1, 0, 0));
      // Operand-size prefix keeps bits 31:16
      add_entry("or_imm_edx_hi", ri(0, AK_OR, EDX, 32'hABCD_0000), EDX, 32'hABCD_F000,
                flg(0, 0, 1, 0));
      add_entry("add16_dx_carry", ri(1, AK_ADD, EDX, 32'h1000), EDX, 32'hABCD_0000, flg(1, 1, 0, 0));
      add_entry("sub16_dx_cx", rr(1, OP_SUB, EDX, ECX), EDX, 32'hABCD_0001, flg(1, 0, 0, 0));
      add_entry("add16_ax_7fff", ri(1, AK_ADD, EAX, 32'h7FFF), EAX, 32'h7FFF, flg(0, 0, 0, 0));
      add_entry("add16_ax_ovf", ri(1, AK_ADD, EAX, 32'h1), EAX, 32'h8000, flg(0, 0, 1, 1));
      add_entry("and16_cx", ri(1, AK_AND, ECX, 32'h0F0F), ECX, 32'h7FFF_0F0F, flg(0, 0, 0, 0));
      add_entry("xor16_cx_cx", rr(1, OP_XOR, ECX, ECX), ECX, 32'h7FFF_0000, flg(0, 1, 0, 0));
      // Encodings outside the supported subset
      add_invalid("mem_form_add", {8'h01, 8'h18, 48'h0});
      add_invalid("grp1_adc", ri(0, 3'd2, EAX, 32'h5));
      add_invalid("grp1_cmp", ri(0, 3'd7, EAX, 32'h5));
      add_invalid("unknown_opcode", {8'h0F, 8'hC0, 48'h0});
      add_entry("add_eax_ecx_after", rr(0, OP_ADD, EAX, ECX), EAX, 32'h7FFF_8000, flg(0, 0, 0, 0));
      // Random XOR immediates against the running register model
      for (int j = 0; j < N_RAND; j++) begin
         imm = $random(seed);
         dr  = j[RW-1:0];
         res = model_gpr[dr] ^ imm;
         add_entry($sformatf("xor_rand_%0d", j), ri(0, AK_XOR, dr, imm), dr, res,
                   flg(0, res == '0, res[DW-1], 0));
      end
   endtask

   task automatic check_dr(input string name, input logic [RW-1:0] exp, input logic [RW-1:0] act);
      if (act !== exp) begin
         $display("FAILED %s: dr expected %0d, actual %0d", name, exp, act);
         test_err++;
      end
   endtask

   task automatic check_data(input string name, input logic [DW-1:0] exp,
                             input logic [DW-1:0] act);
      if (act !== exp) begin
         $display("FAILED %s: data expected %08h, actual %08h", name, exp, act);
         test_err++;
      end
   endtask

   task automatic check_flags(input string name, input logic [FW-1:0] exp,
                              input logic [FW-1:0] act);
      if (act !== exp) begin
         $display("FAILED %s: flags expected %04b, actual %04b", name, exp, act);
         test_err++;
      end
   endtask

   // Called once per falling edge, retire outputs are stable here
   task automatic check_retire();
      int idx;
      bit due;
      due = (pend_idx.size() > 0) && (pend_edge[0] + LATENCY == cycle);
      if ($isunknown(retire_valid)) begin
         $display("ERROR: retire_valid is unknown in cycle %0d", cycle);
         n_other++;
      end else if (due) begin
         idx = pend_idx.pop_front();
         void'(pend_edge.pop_front());
         test_err = 0;
         if (exp_t[idx] && retire_valid) begin
            check_dr(name_t[idx], dr_t[idx], retire_dr);
            check_data(name_t[idx], data_t[idx], retire_data);
            check_flags(name_t[idx], flags_t[idx], retire_flags);
         end else if (exp_t[idx]) begin
            $display("ERROR: %s did not retire three cycles after issue", name_t[idx]);
            test_err++;
         end else if (retire_valid) begin
            $display("ERROR: %s is not a supported encoding but it retired", name_t[idx]);
            test_err++;
         end
         n_run++;
         if (test_err == 0) begin
            n_pass++;
            $display("test %s: pass", name_t[idx]);
         end else begin
            n_fail++;
            $display("test %s: fail", name_t[idx]);
         end
      end else if (retire_valid) begin
         $display("ERROR: retire of register %0d in cycle %0d matches no issue", retire_dr, cycle);
         n_other++;
      end
   endtask

   initial begin
      CLK      = 1'b0;
      rst      = 1'b1;
      ir_valid = 1'b0;
      ir       = '0;
      seed     = 14822;
      build_table();
      table_ready = 1'b1;
      repeat (10) begin
         @(negedge CLK);
         check_retire();
      end
      rst = 1'b0;
      repeat (4) begin
         @(negedge CLK);
         check_retire();
      end
      // One instruction per cycle, no gaps
      for (int i = 0; i < n_tests; i++) begin
         @(negedge CLK);
         check_retire();
         ir_valid = 1'b1;
         ir       = win_t[i];
         pend_idx.push_back(i);
         pend_edge.push_back(cycle + 1);
      end
      @(negedge CLK);
      check_retire();
      ir_valid = 1'b0;
      ir       = '0;
      while (pend_idx.size() > 0) begin
         @(negedge CLK);
         check_retire();
      end
      repeat (4) begin
         @(negedge CLK);
         check_retire();
      end
      $display("Tests: %0d run, %0d passed, %0d failed, %0d other errors, %0d assert fails",
               n_run, n_pass, n_fail, n_other,
               x86_pipeline_inst.x86_pipeline_properties_inst.fail_count);
      if (n_fail == 0 && n_other == 0 && n_run == n_tests &&
          x86_pipeline_inst.x86_pipeline_properties_inst.fail_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      wait (table_ready);
      #((n_tests + 40) * CLK_PERIOD * 2);
      $display("ERROR: watchdog expired before all tests finished");
      $display("Simulation failed");
      $finish;
   end

endmodule
